/* design/dwt_apb_regs.sv */
`timescale 1ns/1ps
`include "dwt_macros.svh"

module dwt_apb_regs import dwt_pkg::*;
(
  input  logic        clk,
  input  logic        rst_global,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apb_addr_t   paddr,
  input  apb_data_t   pwdata,
  output apb_data_t   prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        busy,
  input  logic        done,
  output logic        start,
  output level_t      levels,
  sample_port_if.host sp
);

  apb_addr_t   sample_ofs;
  logic        is_ctrl;
  logic        is_status;
  logic        is_sample;
  logic        access;
  logic        lvl_bad;
  int unsigned req_levels;

  assign sample_ofs = paddr - `DWT_SAMPLE_BASE;
  assign is_ctrl    = (paddr == `DWT_CTRL_OFS);
  assign is_status  = (paddr == `DWT_STATUS_OFS);
  assign is_sample  = (paddr >= `DWT_SAMPLE_BASE) &&
                      (sample_ofs < apb_addr_t'(`DWT_N * 4)) &&
                      (paddr[1:0] == 2'b00);

  assign req_levels = 32'(pwdata[2:1]);
  assign lvl_bad    = (req_levels == 0) || (req_levels > `DWT_MAX_LEVELS);

  // only status answers while a transform runs
  assign pready  = !(psel && busy && !is_status);
  assign access  = psel && penable && pready;
  assign pslverr = access && (!(is_ctrl || is_status || is_sample) ||
                              (is_ctrl && pwrite && lvl_bad));

  assign sp.en    = access && is_sample;
  assign sp.we    = pwrite;
  assign sp.idx   = idx_t'(sample_ofs >> 2);
  assign sp.wdata = sample_t'(pwdata[`DWT_SAMPLE_W-1:0]);

  always_comb
  begin
    prdata = '0;
    if (is_status)
    begin
      prdata = {{(`DWT_DATA_W-2){1'b0}}, done, busy};
    end
    else if (is_sample)
    begin
      prdata = {{(`DWT_DATA_W-`DWT_SAMPLE_W){sp.rdata[`DWT_SAMPLE_W-1]}}, sp.rdata};
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_global)
    begin
      start  <= 1'b0;
      levels <= level_t'(1);
    end
    else
    begin
      start <= 1'b0;  // single cycle pulse
      if (access && pwrite && is_ctrl && !lvl_bad)
      begin
        start  <= pwdata[0];
        levels <= pwdata[2:1];
      end
    end
  end

endmodule

/* design/dwt_macros.svh */
`ifndef DWT_MACROS_SVH
`define DWT_MACROS_SVH

// bank geometry
`define DWT_N            16
`define DWT_SAMPLE_W     16
`define DWT_MAX_LEVELS   3

// apb bus
`define DWT_ADDR_W       8
`define DWT_DATA_W       32

// register map with one word per sample in the window
`define DWT_CTRL_OFS     8'h00
`define DWT_STATUS_OFS   8'h04
`define DWT_SAMPLE_BASE  8'h40

`define DWT_UPD_ROUND    2

`endif

/* design/dwt_pkg.sv */
`include "dwt_macros.svh"

package dwt_pkg;

  typedef logic signed [`DWT_SAMPLE_W-1:0]          sample_t;
  typedef logic [`DWT_N*`DWT_SAMPLE_W-1:0]          sample_vec_t;
  typedef logic [$clog2(`DWT_N)-1:0]                idx_t;
  typedef logic [1:0]                               level_t;
  typedef logic [`DWT_ADDR_W-1:0]                   apb_addr_t;
  typedef logic [`DWT_DATA_W-1:0]                   apb_data_t;

  typedef enum logic [1:0] {
    IDLE,
    LIFT,
    DONE
  } lift_state_t;

  typedef enum logic {
    PREDICT,
    UPDATE
  } lift_step_t;

endpackage

/* design/dwt_top.sv */
`timescale 1ns/1ps

module dwt_top import dwt_pkg::*;
(
  input  logic      clk,
  input  logic      rst_global,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  logic        start;
  level_t      levels;
  logic        busy;
  logic        done;
  logic        cnt_clear;
  logic        cnt_advance;
  logic        lift_en;
  logic        last;
  lift_step_t  step;
  level_t      level;
  sample_vec_t samples;
  sample_vec_t next_samples;

  sample_port_if sp_if ();

  dwt_apb_regs regs_i (
    .clk        (clk),
    .rst_global (rst_global),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .busy       (busy),
    .done       (done),
    .start      (start),
    .levels     (levels),
    .sp         (sp_if.host)
  );

  lift_fsm fsm_i (
    .clk         (clk),
    .rst_global  (rst_global),
    .start       (start),
    .last        (last),
    .cnt_clear   (cnt_clear),
    .cnt_advance (cnt_advance),
    .lift_en     (lift_en),
    .busy        (busy),
    .done        (done)
  );

  lift_step_counter cnt_i (
    .clk        (clk),
    .rst_global (rst_global),
    .clear      (cnt_clear),
    .advance    (cnt_advance),
    .levels     (levels),
    .step       (step),
    .level      (level),
    .last       (last)
  );

  lift_unit_array units_i (
    .samples      (samples),
    .step         (step),
    .level        (level),
    .next_samples (next_samples)
  );

  sample_bank bank_i (
    .clk          (clk),
    .rst_global   (rst_global),
    .lift_en      (lift_en),
    .next_samples (next_samples),
    .samples      (samples),
    .sp           (sp_if.bank)
  );

endmodule

/* design/lift_fsm.sv */
`timescale 1ns/1ps

module lift_fsm import dwt_pkg::*;
(
  input  logic clk,
  input  logic rst_global,
  input  logic start,
  input  logic last,
  output logic cnt_clear,
  output logic cnt_advance,
  output logic lift_en,
  output logic busy,
  output logic done
);

  lift_state_t state_q;
  lift_state_t state_d;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE:
        if (start)
          state_d = LIFT;
      LIFT:
        if (last)
          state_d = DONE;  // update of final level just loaded
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst_global)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  assign cnt_clear   = start && (state_q != LIFT);
  assign cnt_advance = (state_q == LIFT);
  assign lift_en     = (state_q == LIFT);  // bank takes array output each lift cycle
  assign busy        = (state_q == LIFT);
  assign done        = (state_q == DONE);

endmodule

/* design/lift_step_counter.sv */
`timescale 1ns/1ps

module lift_step_counter import dwt_pkg::*;
(
  input  logic       clk,
  input  logic       rst_global,
  input  logic       clear,
  input  logic       advance,
  input  level_t     levels,
  output lift_step_t step,
  output level_t     level,
  output logic       last
);

  always_ff @(posedge clk)
  begin
    if (rst_global || clear)
    begin
      step  <= PREDICT;
      level <= '0;
    end
    else if (advance)
    begin
      if (step == PREDICT)
      begin
        step <= UPDATE;
      end
      else
      begin
        step  <= PREDICT;
        level <= level + level_t'(1);  // next octave after update
      end
    end
  end

  assign last = (step == UPDATE) && (level == levels - level_t'(1));

endmodule

/* design/lift_unit_array.sv */
`timescale 1ns/1ps
`include "dwt_macros.svh"

module lift_unit_array import dwt_pkg::*;
(
  input  sample_vec_t samples,
  input  lift_step_t  step,
  input  level_t      level,
  output sample_vec_t next_samples
);

  localparam int HALF = `DWT_N / 2;

  sample_t cur [`DWT_N];
  idx_t    unit_tgt [HALF];
  sample_t unit_val [HALF];
  logic    unit_act [HALF];

  always_comb
  begin
    for (int i = 0; i < `DWT_N; i++)
    begin
      cur[i] = samples[i*`DWT_SAMPLE_W +: `DWT_SAMPLE_W];
    end
  end

  for (genvar k = 0; k < HALF; k++)
  begin : g_unit
    int      stride;
    int      pairs;
    int      even_i;
    int      odd_i;
    int      even_nx;
    int      odd_pv;
    int      sum;
    sample_t even_s;
    sample_t odd_s;
    sample_t even_n_s;
    sample_t odd_p_s;
    idx_t    tgt;
    sample_t val;

    always_comb
    begin
      stride  = 1 << level;
      pairs   = `DWT_N / (2 * stride);
      even_i  = k * 2 * stride;
      odd_i   = even_i + stride;
      even_nx = (k + 1 < pairs) ? even_i + 2 * stride : even_i;  // last unit repeats its even
      odd_pv  = (k > 0) ? odd_i - 2 * stride : odd_i;            // first unit repeats its odd

      even_s   = cur[idx_t'(even_i)];
      odd_s    = cur[idx_t'(odd_i)];
      even_n_s = cur[idx_t'(even_nx)];
      odd_p_s  = cur[idx_t'(odd_pv)];

      if (step == PREDICT)
      begin
        sum = int'(even_s) + int'(even_n_s);
        tgt = idx_t'(odd_i);
        val = sample_t'(int'(odd_s) - (sum >>> 1));
      end
      else
      begin
        sum = int'(odd_p_s) + int'(odd_s) + `DWT_UPD_ROUND;
        tgt = idx_t'(even_i);
        val = sample_t'(int'(even_s) + (sum >>> 2));
      end
    end

    assign unit_tgt[k] = tgt;
    assign unit_val[k] = val;
    assign unit_act[k] = (k < pairs);
  end

  // untouched positions keep their value
  always_comb
  begin
    sample_t nxt [`DWT_N];
    nxt = cur;
    for (int k = 0; k < HALF; k++)
    begin
      if (unit_act[k])
      begin
        nxt[unit_tgt[k]] = unit_val[k];
      end
    end
    for (int i = 0; i < `DWT_N; i++)
    begin
      next_samples[i*`DWT_SAMPLE_W +: `DWT_SAMPLE_W] = nxt[i];
    end
  end

endmodule

/* design/sample_bank.sv */
`timescale 1ns/1ps
`include "dwt_macros.svh"

module sample_bank import dwt_pkg::*;
(
  input  logic        clk,
  input  logic        rst_global,
  input  logic        lift_en,
  input  sample_vec_t next_samples,
  output sample_vec_t samples,
  sample_port_if.bank sp
);

  sample_t bank_q [`DWT_N];

  always_ff @(posedge clk)
  begin
    if (rst_global)
    begin
      for (int i = 0; i < `DWT_N; i++)
      begin
        bank_q[i] <= '0;
      end
    end
    else if (lift_en)
    begin
      // whole row replaced by the lifting result
      for (int i = 0; i < `DWT_N; i++)
      begin
        bank_q[i] <= next_samples[i*`DWT_SAMPLE_W +: `DWT_SAMPLE_W];
      end
    end
    else if (sp.en && sp.we)
    begin
      bank_q[sp.idx] <= sp.wdata;  // host write
    end
  end

  always_comb
  begin
    for (int i = 0; i < `DWT_N; i++)
    begin
      samples[i*`DWT_SAMPLE_W +: `DWT_SAMPLE_W] = bank_q[i];
    end
  end

  assign sp.rdata = bank_q[sp.idx];

endmodule

/* design/sample_port_if.sv */
`timescale 1ns/1ps

interface sample_port_if import dwt_pkg::*; ();

  logic    en;     // one cycle per completed host access
  logic    we;
  idx_t    idx;
  sample_t wdata;
  sample_t rdata;  // combinational from idx

  modport host (
    output en, we, idx, wdata,
    input  rdata
  );

  modport bank (
    input  en, we, idx, wdata,
    output rdata
  );

endinterface

/* files.f */
+incdir+design
design/dwt_pkg.sv
design/sample_port_if.sv
design/dwt_apb_regs.sv
design/lift_fsm.sv
design/lift_step_counter.sv
design/lift_unit_array.sv
design/sample_bank.sv
design/dwt_top.sv
tests/tb_dwt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run the testbench and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f files.f --top-module tb_dwt -o tb_dwt \
  && ./obj_dir/tb_dwt > sim.log 2>&1 \
  || echo "build or simulation returned an error"
grep -q "All tests passed!" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

/* tests/tb_dwt.sv */
`timescale 1ns/1ps
`include "dwt_macros.svh"

module tb_dwt import dwt_pkg::*; ();

  localparam int        MAX_CYCLES = 4000;  // ~300 accesses at ~3 cycles plus transforms
  localparam apb_addr_t UNMAPPED   = 8'h20;

  logic      clk = 1'b0;
  logic      rst_global;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  sample_t     ref_bank [`DWT_N];  // expected bank contents
  int unsigned lcg_state = 27;
  int          cycle_cnt = 0;

  dwt_top dut_i (.*);

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES)
      report_failure("Timeout: the run went past the cycle limit without finishing");
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0d ns: %s got %0d expected %0d",
                               $time, name, got, exp));
  endtask

  task automatic check_status(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0d ns: %s got %b expected %b",
                               $time, name, got, exp));
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0d ns: %s got %b expected %b",
                               $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                               $time, name, got, exp));
  endtask

  function automatic sample_t lcg_sample();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return sample_t'(lcg_state[30:15]);
  endfunction

  function automatic int floor_div(input int a, input int d);
    int q;
    q = a / d;
    if ((a % d != 0) && (a < 0))
      q = q - 1;  // round toward minus infinity
    return q;
  endfunction

  // 5/3 lifting on the expected bank level by level
  task automatic lift_model(input int levels);
    int stride;
    int pairs;
    int ev;
    int od;
    int nb;
    for (int l = 0; l < levels; l++)
    begin
      stride = 1 << l;
      pairs  = `DWT_N / (2 * stride);
      for (int k = 0; k < pairs; k++)
      begin
        ev = 2 * k * stride;
        nb = (k == pairs - 1) ? ev : ev + 2 * stride;
        ref_bank[ev + stride] = sample_t'(int'(ref_bank[ev + stride]) -
                                          floor_div(int'(ref_bank[ev]) + int'(ref_bank[nb]), 2));
      end
      for (int k = 0; k < pairs; k++)
      begin
        ev = 2 * k * stride;
        od = ev + stride;
        nb = (k == 0) ? od : od - 2 * stride;
        ref_bank[ev] = sample_t'(int'(ref_bank[ev]) +
                                 floor_div(ref_bank[nb] + ref_bank[od] + 2, 4));
      end
    end
  endtask

  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err, output int waits);
    waits = 0;
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready)
    begin
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t rd;
    int        waits;
    apb_access(1'b1, addr, data, rd, err, waits);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err,
                          output int waits);
    apb_access(1'b0, addr, '0, data, err, waits);
  endtask

  task automatic write_sample(input int idx, input sample_t s);
    logic err;
    apb_write(apb_addr_t'(`DWT_SAMPLE_BASE + 4 * idx), {16'hA5A5, s}, err);  // junk upper half
    check_err("pslverr on sample write", err, 1'b0);
  endtask

  task automatic read_sample(input int idx, output sample_t s, output int waits);
    apb_data_t rd;
    logic      err;
    apb_read(apb_addr_t'(`DWT_SAMPLE_BASE + 4 * idx), rd, err, waits);
    check_err("pslverr on sample read", err, 1'b0);
    check_word($sformatf("sample[%0d] read data", idx), rd, {{16{rd[15]}}, rd[15:0]});
    s = sample_t'(rd[15:0]);
  endtask

  task automatic read_status(output logic [1:0] st);
    apb_data_t rd;
    logic      err;
    int        waits;
    apb_read(`DWT_STATUS_OFS, rd, err, waits);
    check_err("pslverr on status read", err, 1'b0);
    st = rd[1:0];
  endtask

  task automatic load_bank();
    for (int i = 0; i < `DWT_N; i++)
      write_sample(i, ref_bank[i]);
  endtask

  task automatic check_bank();
    sample_t s;
    int      waits;
    for (int i = 0; i < `DWT_N; i++)
    begin
      read_sample(i, s, waits);
      check_sample($sformatf("sample[%0d]", i), s, ref_bank[i]);
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < `DWT_N; i++)
      ref_bank[i] = lcg_sample();
  endtask

  task automatic start_transform(input int levels);
    logic err;
    apb_write(`DWT_CTRL_OFS, apb_data_t'((levels << 1) | 1), err);
    check_err("pslverr on ctrl write", err, 1'b0);
  endtask

  task automatic wait_done();
    logic [1:0] st;
    do
      read_status(st);
    while (!st[1]);
  endtask

  task automatic run_and_check(input int levels);
    logic [1:0] st;
    load_bank();
    start_transform(levels);
    read_status(st);
    check_status("status during transform", st, 2'b01);  // busy set and old done cleared
    wait_done();
    lift_model(levels);
    check_bank();
    read_status(st);
    check_status("status after transform", st, 2'b10);
  endtask

  task automatic reset_values();
    logic [1:0] st;
    read_status(st);
    check_status("status after reset", st, 2'b00);
    for (int i = 0; i < `DWT_N; i++)
      ref_bank[i] = '0;
    check_bank();
  endtask

  task automatic sample_readback();
    for (int i = 0; i < `DWT_N; i++)
      ref_bank[i] = sample_t'((i % 2) ? -(i * 1111) : i * 1234 + 7);
    ref_bank[1] = sample_t'(-32768);
    ref_bank[2] = sample_t'(32767);
    load_bank();
    check_bank();
  endtask

  task automatic one_level_transform();
    for (int i = 0; i < `DWT_N; i++)
      ref_bank[i] = sample_t'(5 * i - 20);  // ramp
    run_and_check(1);
    fill_random();
    run_and_check(1);
  endtask

  task automatic three_level_transform();
    fill_random();
    run_and_check(3);
  endtask

  task automatic back_pressure();
    logic [1:0] st;
    sample_t    s;
    int         waits;
    fill_random();
    load_bank();
    start_transform(3);
    lift_model(3);
    read_sample(5, s, waits);
    if (waits != 2 * 3 - 1)  // busy cycles after the setup phase
      report_failure($sformatf("Mismatch at %0d ns: read wait states got %0d expected %0d",
                               $time, waits, 2 * 3 - 1));
    check_sample("sample[5] after stall", s, ref_bank[5]);
    read_status(st);
    check_status("status after stalled read", st, 2'b10);
    check_bank();
  endtask

  task automatic error_responses();
    logic [1:0] st;
    apb_data_t  rd;
    logic       err;
    int         waits;
    apb_read(UNMAPPED, rd, err, waits);
    check_err("pslverr on unmapped read", err, 1'b1);
    check_word("unmapped read data", rd, '0);
    apb_write(UNMAPPED, 32'h0000_1234, err);
    check_err("pslverr on unmapped write", err, 1'b1);
    apb_write(`DWT_CTRL_OFS, 32'h0000_0001, err);  // start with level count 0
    check_err("pslverr on bad level count", err, 1'b1);
    read_status(st);
    check_status("status after error accesses", st, 2'b10);  // done kept from last run
    check_bank();
  endtask

  initial
  begin
    rst_global = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_global = 1'b0;
    reset_values();
    sample_readback();
    one_level_transform();
    three_level_transform();
    back_pressure();
    error_responses();
    $display("All tests passed!");
    $finish;
  end

endmodule
